// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= data_memory_tb
BUILD_DIR ?= build
FILELIST ?= project.f
VFLAGS ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST) test/data_memory_stim.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
rtl/mem_pkg.sv
rtl/load_issue_filter.sv
rtl/store_commit_buffer.sv
rtl/byte_memory.sv
rtl/load_result_format.sv
rtl/data_memory_top.sv
test/data_memory_tb.sv

// ==== rtl/byte_memory.sv ====
`timescale 1ns/1ps

module byte_memory (
    input logic clk,
    input logic reset,
    input logic ld_valid,
    input logic [mem_pkg::addr_bits-1:0] ld_addr,
    input mem_pkg::load_width_t ld_width,
    input logic [mem_pkg::tag_bits-1:0] ld_tag,
    input logic st_valid,
    input logic [mem_pkg::addr_bits-1:0] st_addr,
    input logic [31:0] st_data,
    input mem_pkg::store_width_t st_width,
    output logic st_take,
    output logic rd_valid,
    output logic [31:0] rd_word,
    output mem_pkg::load_width_t rd_width,
    output logic [mem_pkg::tag_bits-1:0] rd_tag
);
    import mem_pkg::*;

    logic [7:0] mem [mem_bytes];

    // Byte addresses past the base, wrapping at the top of memory
    logic [addr_bits-1:0] st_a1;
    logic [addr_bits-1:0] st_a2;
    logic [addr_bits-1:0] st_a3;
    logic [addr_bits-1:0] ld_a1;
    logic [addr_bits-1:0] ld_a2;
    logic [addr_bits-1:0] ld_a3;

    assign st_a1 = st_addr + addr_bits'(1);
    assign st_a2 = st_addr + addr_bits'(2);
    assign st_a3 = st_addr + addr_bits'(3);
    assign ld_a1 = ld_addr + addr_bits'(1);
    assign ld_a2 = ld_addr + addr_bits'(2);
    assign ld_a3 = ld_addr + addr_bits'(3);

    assign st_take = st_valid && !ld_valid; // Loads own the port when present

    // Big-endian byte lanes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_bytes; i++) begin
                mem[i] <= '0;
            end
        end else if (st_take) begin
            case (st_width)
                SW: begin
                    mem[st_addr] <= st_data[31:24];
                    mem[st_a1] <= st_data[23:16];
                    mem[st_a2] <= st_data[15:8];
                    mem[st_a3] <= st_data[7:0];
                end
                SH: begin
                    mem[st_addr] <= st_data[15:8];
                    mem[st_a1] <= st_data[7:0];
                end
                SB: mem[st_addr] <= st_data[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ld_valid;
        end
    end

    // Always fetch a full word, the formatter picks the bytes
    always_ff @(posedge clk) begin
        if (ld_valid) begin
            rd_word <= {mem[ld_addr], mem[ld_a1], mem[ld_a2], mem[ld_a3]};
            rd_width <= ld_width;
            rd_tag <= ld_tag;
        end
    end

endmodule

// ==== rtl/data_memory_top.sv ====
`timescale 1ns/1ps

module data_memory_top (
    input logic clk,
    input logic reset,
    input logic issued,
    input logic [6:0] opcode,
    input logic [2:0] func3,
    input logic [31:0] addr,
    input logic [mem_pkg::tag_bits-1:0] rob_index,
    input logic store_wb,
    input logic [31:0] store_addr,
    input logic [31:0] store_data,
    input mem_pkg::store_width_t store_width,
    output logic store_ready,
    output logic store_pending,
    output logic valid,
    output logic [31:0] data_out,
    output logic [mem_pkg::tag_bits-1:0] tag_out
);
    import mem_pkg::*;

    // Filter to memory
    logic ld_valid;
    logic [addr_bits-1:0] ld_addr;
    load_width_t ld_width;
    logic [tag_bits-1:0] ld_tag;

    // Store buffer to memory
    logic st_valid;
    logic st_take;
    logic [addr_bits-1:0] st_addr;
    logic [31:0] st_data;
    store_width_t st_width;

    // Memory to formatter
    logic rd_valid;
    logic [31:0] rd_word;
    load_width_t rd_width;
    logic [tag_bits-1:0] rd_tag;

    load_issue_filter filter_i (
        .clk(clk),
        .reset(reset),
        .issued(issued),
        .opcode(opcode),
        .func3(func3),
        .addr(addr),
        .rob_index(rob_index),
        .ld_valid(ld_valid),
        .ld_addr(ld_addr),
        .ld_width(ld_width),
        .ld_tag(ld_tag)
    );

    store_commit_buffer store_buf_i (
        .clk(clk),
        .reset(reset),
        .store_wb(store_wb),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_width(store_width),
        .st_take(st_take),
        .store_ready(store_ready),
        .store_pending(store_pending),
        .st_valid(st_valid),
        .st_addr(st_addr),
        .st_data(st_data),
        .st_width(st_width)
    );

    byte_memory mem_i (
        .clk(clk),
        .reset(reset),
        .ld_valid(ld_valid),
        .ld_addr(ld_addr),
        .ld_width(ld_width),
        .ld_tag(ld_tag),
        .st_valid(st_valid),
        .st_addr(st_addr),
        .st_data(st_data),
        .st_width(st_width),
        .st_take(st_take),
        .rd_valid(rd_valid),
        .rd_word(rd_word),
        .rd_width(rd_width),
        .rd_tag(rd_tag)
    );

    load_result_format format_i (
        .clk(clk),
        .reset(reset),
        .rd_valid(rd_valid),
        .rd_word(rd_word),
        .rd_width(rd_width),
        .rd_tag(rd_tag),
        .valid(valid),
        .data_out(data_out),
        .tag_out(tag_out)
    );

endmodule

// ==== rtl/load_issue_filter.sv ====
`timescale 1ns/1ps

module load_issue_filter (
    input logic clk,
    input logic reset,
    input logic issued,
    input logic [6:0] opcode,
    input logic [2:0] func3,
    input logic [31:0] addr,
    input logic [mem_pkg::tag_bits-1:0] rob_index,
    output logic ld_valid,
    output logic [mem_pkg::addr_bits-1:0] ld_addr,
    output mem_pkg::load_width_t ld_width,
    output logic [mem_pkg::tag_bits-1:0] ld_tag
);
    import mem_pkg::*;

    logic [tag_bits-1:0] last_tag;
    logic tag_seen; // No tag to compare against until the first accept
    logic accept;

    // The FU may hold a request for more than one cycle, same tag means same load
    assign accept = issued && (opcode == opcode_load) &&
                    (!tag_seen || (rob_index != last_tag));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ld_valid <= 1'b0;
            tag_seen <= 1'b0;
            last_tag <= '0;
        end else begin
            ld_valid <= accept;
            if (accept) begin
                tag_seen <= 1'b1;
                last_tag <= rob_index;
            end
        end
    end

    // Request payload toward memory
    always_ff @(posedge clk) begin
        if (accept) begin
            ld_addr <= addr[addr_bits-1:0];
            ld_width <= load_width_t'(func3);
            ld_tag <= rob_index;
        end
    end

endmodule

// ==== rtl/load_result_format.sv ====
`timescale 1ns/1ps

module load_result_format (
    input logic clk,
    input logic reset,
    input logic rd_valid,
    input logic [31:0] rd_word,
    input mem_pkg::load_width_t rd_width,
    input logic [mem_pkg::tag_bits-1:0] rd_tag,
    output logic valid,
    output logic [31:0] data_out,
    output logic [mem_pkg::tag_bits-1:0] tag_out
);
    import mem_pkg::*;

    logic [31:0] ext_word;

    // Addressed byte sits in the top lane of the word
    always_comb begin
        case (rd_width)
            LB: ext_word = {{24{rd_word[31]}}, rd_word[31:24]};
            LH: ext_word = {{16{rd_word[31]}}, rd_word[31:16]};
            LBU: ext_word = {24'b0, rd_word[31:24]};
            LHU: ext_word = {16'b0, rd_word[31:16]};
            default: ext_word = rd_word; // LW
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            data_out <= ext_word;
            tag_out <= rd_tag;
        end
    end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // Memory geometry
    localparam int mem_bytes = 65536;
    localparam int addr_bits = 16; // Upper address bits dropped, so accesses wrap

    // ROB tag width
    localparam int tag_bits = 5;

    // Committed store FIFO, depth kept a power of two
    localparam int store_depth = 4;
    localparam int store_ptr_bits = $clog2(store_depth);

    // RV32 major opcodes
    localparam logic [6:0] opcode_load = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // Load widths, encoded as funct3
    typedef enum logic [2:0] {
        LB = 3'b000,
        LH = 3'b001,
        LW = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_width_t;

    // Store widths as supplied by the LSQ
    typedef enum logic [1:0] {
        SW = 2'b00,
        SH = 2'b01,
        SB = 2'b10
    } store_width_t;

endpackage

// ==== rtl/store_commit_buffer.sv ====
`timescale 1ns/1ps

module store_commit_buffer (
    input logic clk,
    input logic reset,
    input logic store_wb,
    input logic [31:0] store_addr,
    input logic [31:0] store_data,
    input mem_pkg::store_width_t store_width,
    input logic st_take,
    output logic store_ready,
    output logic store_pending,
    output logic st_valid,
    output logic [mem_pkg::addr_bits-1:0] st_addr,
    output logic [31:0] st_data,
    output mem_pkg::store_width_t st_width
);
    import mem_pkg::*;

    logic [addr_bits-1:0] addr_q [store_depth];
    logic [31:0] data_q [store_depth];
    store_width_t width_q [store_depth];

    logic [store_ptr_bits-1:0] wr_ptr;
    logic [store_ptr_bits-1:0] rd_ptr;
    logic [store_ptr_bits:0] count;

    logic push;
    logic pop;

    assign store_ready = (count != store_depth);
    assign store_pending = (count != 0);
    assign st_valid = (count != 0);

    assign push = store_wb && store_ready;
    assign pop = st_take && st_valid;

    // Head entry
    assign st_addr = addr_q[rd_ptr];
    assign st_data = data_q[rd_ptr];
    assign st_width = width_q[rd_ptr];

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= store_addr[addr_bits-1:0];
            data_q[wr_ptr] <= store_data;
            width_q[wr_ptr] <= store_width;
        end
    end

endmodule

// ==== test/data_memory_stim.txt ====
// op st_width st_addr st_data ld_opcode funct3 ld_addr tag exp_data exp_flag
// op bits: 1 store, 2 load, 4 wait for store drain, 8 expect buffer full; ff ends
2 0 00000000 00000000 03 2 0000fff0 01 00000000 1
1 0 00000100 8a3c5e71 00 0 00000000 00 00000000 0
1 0 00000200 11223344 00 0 00000000 00 00000000 0
1 1 00000200 5a5ac3d4 00 0 00000000 00 00000000 0
1 2 00000203 000000e7 00 0 00000000 00 00000000 0
4 0 00000000 00000000 00 0 00000000 00 00000000 0
2 0 00000000 00000000 03 2 00000100 02 8a3c5e71 1
2 0 00000000 00000000 03 2 00000200 03 c3d433e7 1
2 0 00000000 00000000 03 1 00000200 04 ffffc3d4 1
2 0 00000000 00000000 03 5 00000200 05 0000c3d4 1
2 0 00000000 00000000 03 0 00000200 06 ffffffc3 1
2 0 00000000 00000000 03 4 00000203 07 000000e7 1
2 0 00000000 00000000 03 1 00000202 08 000033e7 1
2 0 00000000 00000000 03 0 00000202 09 00000033 1
2 0 00000000 00000000 03 2 00000200 09 00000000 0
2 0 00000000 00000000 23 2 00000100 0a 00000000 0
3 0 00000400 a1000001 03 2 00000100 10 8a3c5e71 1
3 0 00000404 a2000002 03 5 00000200 11 0000c3d4 1
3 1 00000408 0000b3b3 03 4 00000100 12 0000008a 1
3 2 0000040c 000000c4 03 1 00000100 13 ffff8a3c 1
a 0 00000000 00000000 03 0 00000101 14 0000003c 1
1 0 00000410 d5000005 00 0 00000000 00 00000000 0
1 0 00000414 e6000006 00 0 00000000 00 00000000 0
4 0 00000000 00000000 00 0 00000000 00 00000000 0
2 0 00000000 00000000 03 2 00000400 15 a1000001 1
2 0 00000000 00000000 03 2 00000404 16 a2000002 1
2 0 00000000 00000000 03 2 00000408 17 b3b30000 1
2 0 00000000 00000000 03 2 0000040c 18 c4000000 1
2 0 00000000 00000000 03 2 00000410 19 d5000005 1
2 0 00000000 00000000 03 2 00000414 1a e6000006 1
2 0 00000000 00000000 03 2 00010100 1b 8a3c5e71 1
ff 0 00000000 00000000 00 0 00000000 00 00000000 0

// ==== test/data_memory_tb.sv ====
`timescale 1ns/1ps

module data_memory_tb;
    import mem_pkg::*;

    localparam int cols = 10; // Words per stim line
    localparam int max_lines = 64;

    logic clk;
    logic reset;
    logic issued;
    logic [6:0] opcode;
    logic [2:0] func3;
    logic [31:0] addr;
    logic [tag_bits-1:0] rob_index;
    logic store_wb;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    store_width_t store_width;
    logic store_ready;
    logic store_pending;
    logic valid;
    logic [31:0] data_out;
    logic [tag_bits-1:0] tag_out;

    logic [31:0] stim [cols*max_lines];
    logic [31:0] exp_data_q [$];
    logic [tag_bits-1:0] exp_tag_q [$];
    int due_q [$]; // Cycle each result should show up
    int cycle = 0;
    int limit = 0;
    int errors = 0;
    int nlines;

    data_memory_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_data(input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: data_out expected %h, got %h", $time, expected, actual);
        end
    endtask

    task automatic check_tag(input logic [tag_bits-1:0] expected,
                             input logic [tag_bits-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: tag_out expected %h, got %h", $time, expected, actual);
        end
    endtask

    // Op bit 0 stores, bit 1 loads, bit 2 waits for the drain, bit 3 expects a full buffer
    task automatic run_line(input int base);
        logic [3:0] op;
        op = stim[base][3:0];
        @(posedge clk);
        store_wb <= op[0];
        issued <= op[1];
        if (op[0]) begin
            store_width <= store_width_t'(stim[base+1][1:0]);
            store_addr <= stim[base+2];
            store_data <= stim[base+3];
        end
        if (op[1]) begin
            opcode <= stim[base+4][6:0];
            func3 <= stim[base+5][2:0];
            addr <= stim[base+6];
            rob_index <= stim[base+7][tag_bits-1:0];
        end
        @(negedge clk);
        if (op[1] && stim[base+9][0]) begin
            exp_data_q.push_back(stim[base+8]);
            exp_tag_q.push_back(stim[base+7][tag_bits-1:0]);
            due_q.push_back(cycle + 3);
        end
        if (op[3] && store_ready) begin
            errors++;
            $display("Store buffer not full at %0t, store_ready is still high", $time);
        end
        // The store sent on the line before has just been taken
        if (op[2] && !store_pending) begin
            errors++;
            $display("Store buffer empty at %0t right after a store, store_pending is low",
                     $time);
        end
        // Hold the store until the buffer has room
        while (op[0] && !store_ready) begin
            @(posedge clk);
            issued <= 1'b0;
            @(negedge clk);
        end
        while (op[2] && store_pending) @(negedge clk);
    endtask

    // Results come back in issue order
    always @(negedge clk) begin
        if (valid) begin
            if (due_q.size() == 0) begin
                errors++;
                $display("Result with tag %h at %0t but no load in flight", tag_out, $time);
            end else begin
                if (due_q[0] != cycle) begin
                    errors++;
                    $display("Result for tag %h came at cycle %0d, expected at cycle %0d",
                             exp_tag_q[0], cycle, due_q[0]);
                end
                check_data(exp_data_q.pop_front(), data_out);
                check_tag(exp_tag_q.pop_front(), tag_out);
                void'(due_q.pop_front());
            end
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            errors++;
            $display("No result for the load with tag %h due at cycle %0d",
                     exp_tag_q[0], due_q[0]);
            void'(exp_data_q.pop_front());
            void'(exp_tag_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    initial begin
        reset = 1'b1;
        issued = 1'b0;
        opcode = '0;
        func3 = '0;
        addr = '0;
        rob_index = '0;
        store_wb = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_width = SW;
        $readmemh("test/data_memory_stim.txt", stim);
        nlines = 0;
        while (nlines < max_lines && stim[nlines*cols] != 32'hff) nlines++;
        limit = nlines * 8 + 50;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < nlines; i++) run_line(i * cols);
        @(posedge clk);
        issued <= 1'b0;
        store_wb <= 1'b0;
        while (due_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk); // Catch any stray result
        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        @(negedge clk);
        while (cycle < limit) @(negedge clk);
        errors++;
        $display("Timeout, the run was still going after %0d cycles", limit);
        $display("Run complete with %0d errors", errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
